// ==== all.f ====
+incdir+rtl
rtl/pipeline_pkg.sv
rtl/stage_ifs.sv
rtl/mem_stage.sv
rtl/load_bus_port.sv
rtl/csr_file.sv
rtl/mem_wb_reg.sv
rtl/mem_subsys_top.sv
tb/tb_mem_subsys.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) rtl/mem_params.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"

module tb_mem_subsys;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_TESTS    = 6;
    localparam int WATCHDOG_NS  = (NUM_TESTS * 200 + RESET_CYCLES) * 10;
    localparam logic [7:0] LOAD_OPS [6] = '{`ALU_LDB, `ALU_LDBU, `ALU_LDH, `ALU_LDHU,
                                            `ALU_LDW, `ALU_LLW};

    logic                    clk = 1'b0;
    logic                    arst_n;
    logic                    ex_valid;
    pipeline_pkg::aluop_t    ex_aluop;
    pipeline_pkg::bus32_t    ex_pc;
    pipeline_pkg::bus32_t    ex_mem_addr;
    logic                    ex_reg_write_en;
    pipeline_pkg::reg_addr_t ex_reg_write_addr;
    pipeline_pkg::bus32_t    ex_reg_write_data;
    pipeline_pkg::csr_addr_t ex_csr_addr;
    logic                    ex_csr_read_en;
    logic                    ex_csr_write_en;
    pipeline_pkg::bus32_t    ex_csr_write_data;
    pipeline_pkg::bus32_t    ex_csr_mask;
    logic                    pause_mem;
    logic                    wb_cyc;
    logic                    wb_stb;
    pipeline_pkg::bus32_t    wb_adr;
    pipeline_pkg::bus32_t    wb_dat_i = '0;
    logic                    wb_ack = 1'b0;
    logic                    out_valid;
    pipeline_pkg::bus32_t    out_pc;
    logic                    out_write_en;
    pipeline_pkg::reg_addr_t out_write_addr;
    pipeline_pkg::bus32_t    out_write_data;
    logic                    is_syscall_break;
    logic                    is_ertn;
    logic                    is_idle;
    logic                    estat_access;

    pipeline_pkg::bus32_t    mem [0:15];
    pipeline_pkg::bus32_t    csr_model [0:6];
    pipeline_pkg::bus64_t    tick;
    pipeline_pkg::bus32_t    exp_q [$];
    pipeline_pkg::bus32_t    exp_data;
    pipeline_pkg::bus32_t    exp_pc;
    pipeline_pkg::reg_addr_t exp_waddr;
    pipeline_pkg::bus32_t    pc;
    logic                    exp_valid;
    logic                    exp_we;
    logic [3:0]              exp_flags;
    logic                    cur_load;
    int                      seed = 32'h0c90_c3a9;
    int                      wait_left = -1;
    int                      errors = 0;

    mem_subsys_top dut0 (.*);

    always #5 clk = ~clk;

    // mirrors the stable timer since both count every edge out of reset.
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tick <= '0;
        end else begin
            tick <= tick + 64'd1;
        end
    end

    // wishbone slave that acks 0 to 3 cycles into each cycle.
    always @(posedge clk) begin
        #1;
        wb_ack = 1'b0;
        if (wb_cyc && wb_stb) begin
            if (wait_left < 0) wait_left = $unsigned($random(seed)) % 4;
            if (wait_left == 0) begin
                wb_ack    = 1'b1;
                wb_dat_i  = mem[wb_adr[5:2]];
                wait_left = -1;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    task automatic stop_failed();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(input string msg);
        errors = errors + 1;
        $display("** Error at %0t ns: %s", $time, msg);
        stop_failed();
    endtask

    function automatic int csr_index(input pipeline_pkg::csr_addr_t addr);
        case (addr)
            `CSR_CRMD:  csr_index = 0;
            `CSR_ESTAT: csr_index = 1;
            `CSR_SAVE0: csr_index = 2;
            `CSR_SAVE1: csr_index = 3;
            `CSR_SAVE2: csr_index = 4;
            `CSR_SAVE3: csr_index = 5;
            `CSR_TID:   csr_index = 6;
            default:    csr_index = -1;
        endcase
    endfunction

    function automatic pipeline_pkg::bus32_t lane_value(input pipeline_pkg::aluop_t op,
                                                        input pipeline_pkg::bus32_t word,
                                                        input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8 * off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (op)
            `ALU_LDB:  lane_value = {{24{b[7]}}, b};
            `ALU_LDBU: lane_value = {24'h0, b};
            `ALU_LDH:  lane_value = off[0] ? 32'h0 : {{16{h[15]}}, h}; // odd halfword is zero.
            `ALU_LDHU: lane_value = off[0] ? 32'h0 : {16'h0, h};
            default:   lane_value = word;
        endcase
    endfunction

    // presents one instruction and returns just after the edge that takes it.
    task automatic run_op(input pipeline_pkg::aluop_t op, input pipeline_pkg::bus32_t mem_addr,
                          input pipeline_pkg::bus32_t reg_data,
                          input pipeline_pkg::csr_addr_t csr_addr,
                          input pipeline_pkg::bus32_t csr_data, input pipeline_pkg::bus32_t mask,
                          input pipeline_pkg::bus32_t expected);
        logic is_csr;
        logic special;
        is_csr  = (op == `ALU_CSRRD) || (op == `ALU_CSRWR) || (op == `ALU_CSRXCHG);
        special = (op == `ALU_SYSCALL) || (op == `ALU_BREAK) ||
                  (op == `ALU_ERTN) || (op == `ALU_IDLE);
        exp_q.push_back(expected);
        pc                = pc + 32'd4;
        ex_valid          = 1'b1;
        ex_aluop          = op;
        ex_pc             = pc;
        ex_mem_addr       = mem_addr;
        ex_reg_write_en   = !special;
        ex_reg_write_addr = pc[6:2];
        ex_reg_write_data = reg_data;
        ex_csr_addr       = csr_addr;
        ex_csr_read_en    = is_csr;
        ex_csr_write_en   = (op == `ALU_CSRWR) || (op == `ALU_CSRXCHG);
        ex_csr_write_data = csr_data;
        ex_csr_mask       = mask;
        cur_load          = 1'b0;
        foreach (LOAD_OPS[k]) begin
            if (op == LOAD_OPS[k]) cur_load = 1'b1;
        end
        exp_flags = {(op == `ALU_SYSCALL) || (op == `ALU_BREAK), op == `ALU_ERTN,
                     op == `ALU_IDLE, is_csr && (csr_addr == `CSR_ESTAT)};
        @(negedge clk);
        while (pause_mem) begin
            @(posedge clk);
            #1 exp_valid = 1'b0; // the stall sends bubbles down.
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        exp_valid = 1'b1;
        exp_we    = !special;
        exp_pc    = pc;
        exp_waddr = pc[6:2];
        exp_data  = exp_q.pop_front();
        ex_valid  = 1'b0;
        cur_load  = 1'b0;
        exp_flags = 4'b0;
    endtask

    task automatic do_load(input pipeline_pkg::aluop_t op, input int idx, input logic [1:0] off);
        pipeline_pkg::bus32_t addr;
        addr = 32'h0000_1000 + 32'(idx * 4) + 32'(off);
        run_op(op, addr, 32'h0, 14'h0, 32'h0, 32'h0, lane_value(op, mem[idx], off));
    endtask

    task automatic do_csr(input pipeline_pkg::aluop_t op, input pipeline_pkg::csr_addr_t addr,
                          input pipeline_pkg::bus32_t wdata, input pipeline_pkg::bus32_t mask);
        int                   idx;
        pipeline_pkg::bus32_t old;
        idx = csr_index(addr);
        old = (idx >= 0) ? csr_model[idx] : 32'h0;
        if (idx >= 0 && op == `ALU_CSRWR) csr_model[idx] = wdata;
        if (idx >= 0 && op == `ALU_CSRXCHG) csr_model[idx] = (old & ~mask) | (wdata & mask);
        run_op(op, 32'h0, 32'h0, addr, wdata, mask, old);
    endtask

    task automatic do_timer(input pipeline_pkg::aluop_t op);
        pipeline_pkg::bus32_t expected;
        expected = (op == `ALU_RDCNTVHW) ? tick[63:32] : tick[31:0];
        run_op(op, 32'h0, 32'h0, 14'h0, 32'h0, 32'h0, expected);
    endtask

    task automatic gap();
        @(posedge clk);
        #1 exp_valid = 1'b0;
    endtask

    a_result: assert property (@(posedge clk) disable iff (!arst_n)
        exp_valid |-> out_valid && out_write_en == exp_we && out_write_data == exp_data &&
                      out_pc == exp_pc && out_write_addr == exp_waddr)
        else report_mismatch($sformatf("pc %h wrote r%0d = %h, expected r%0d = %h at pc %h",
            $sampled(out_pc), $sampled(out_write_addr), $sampled(out_write_data),
            $sampled(exp_waddr), $sampled(exp_data), $sampled(exp_pc)));
    a_bubble: assert property (@(posedge clk) disable iff (!arst_n) !exp_valid |-> !out_valid)
        else report_mismatch("out_valid high where a bubble was expected");
    a_pause: assert property (@(posedge clk) disable iff (!arst_n)
        pause_mem == (ex_valid && cur_load && !wb_ack))
        else report_mismatch($sformatf("pause_mem is %b", $sampled(pause_mem)));
    a_cyc_held: assert property (@(posedge clk) disable iff (!arst_n)
        wb_cyc && !wb_ack |=> wb_cyc)
        else report_mismatch("wb_cyc dropped before wb_ack");
    a_flags: assert property (@(posedge clk) disable iff (!arst_n)
        {is_syscall_break, is_ertn, is_idle, estat_access} == exp_flags)
        else report_mismatch($sformatf("flags %b, expected %b", $sampled({is_syscall_break,
            is_ertn, is_idle, estat_access}), $sampled(exp_flags)));

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        stop_failed();
    end

    initial begin
        arst_n            = 1'b0;
        ex_valid          = 1'b0;
        ex_aluop          = `ALU_NOP;
        ex_pc             = '0;
        ex_mem_addr       = '0;
        ex_reg_write_en   = 1'b0;
        ex_reg_write_addr = '0;
        ex_reg_write_data = '0;
        ex_csr_addr       = '0;
        ex_csr_read_en    = 1'b0;
        ex_csr_write_en   = 1'b0;
        ex_csr_write_data = '0;
        ex_csr_mask       = '0;
        exp_valid         = 1'b0;
        exp_we            = 1'b0;
        exp_waddr         = '0;
        exp_flags         = 4'b0;
        cur_load          = 1'b0;
        pc                = 32'h1c00_0000;
        for (int i = 0; i < 16; i++) mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
        for (int i = 0; i < 7; i++) csr_model[i] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;
        assert (!out_valid && !wb_cyc && !wb_stb)
            else report_mismatch("out_valid, wb_cyc or wb_stb active after reset");
        gap();

        foreach (LOAD_OPS[k]) begin
            for (int off = 0; off < 4; off++) begin
                if (off == 0 || k < 4) do_load(LOAD_OPS[k], (k * 4 + off) % 16, 2'(off));
            end
        end
        do_load(`ALU_LDH, 8, 2'd2); // the upper half of this word is negative.

        do_csr(`ALU_CSRWR, `CSR_SAVE0, 32'h1234_5678, 32'h0);
        do_csr(`ALU_CSRRD, `CSR_SAVE0, 32'h0, 32'h0); // served by the forward path.
        do_csr(`ALU_CSRWR, `CSR_SAVE0, 32'ha5a5_0f0f, 32'h0);
        do_csr(`ALU_CSRXCHG, `CSR_SAVE0, 32'hffff_0000, 32'h00ff_ff00);
        do_csr(`ALU_CSRRD, `CSR_SAVE0, 32'h0, 32'h0);
        gap();
        do_csr(`ALU_CSRRD, `CSR_SAVE0, 32'h0, 32'h0);
        do_csr(`ALU_CSRXCHG, `CSR_SAVE3, 32'h0000_beef, 32'h0000_ff0f);
        do_csr(`ALU_CSRRD, 14'h0007, 32'h0, 32'h0);

        do_csr(`ALU_CSRWR, `CSR_TID, 32'h0000_00c3, 32'h0);
        run_op(`ALU_RDCNTID, 32'h0, 32'h0, 14'h0, 32'h0, 32'h0, csr_model[6]);
        gap();
        run_op(`ALU_RDCNTID, 32'h0, 32'h0, 14'h0, 32'h0, 32'h0, csr_model[6]);
        do_timer(`ALU_RDCNTVLW);
        gap();
        do_timer(`ALU_RDCNTVLW);
        do_timer(`ALU_RDCNTVHW);

        run_op(`ALU_SYSCALL, 32'h0, 32'h1111_0001, 14'h0, 32'h0, 32'h0, 32'h1111_0001);
        run_op(`ALU_BREAK, 32'h0, 32'h2222_0002, 14'h0, 32'h0, 32'h0, 32'h2222_0002);
        run_op(`ALU_ERTN, 32'h0, 32'h3333_0003, 14'h0, 32'h0, 32'h0, 32'h3333_0003);
        run_op(`ALU_IDLE, 32'h0, 32'h4444_0004, 14'h0, 32'h0, 32'h0, 32'h4444_0004);
        do_csr(`ALU_CSRWR, `CSR_ESTAT, 32'h0000_0004, 32'h0);
        do_csr(`ALU_CSRRD, `CSR_ESTAT, 32'h0, 32'h0);

        run_op(`ALU_NOP, 32'h0, 32'hcafe_f00d, 14'h0, 32'h0, 32'h0, 32'hcafe_f00d);
        do_load(`ALU_LDW, 3, 2'd0);
        gap();
        repeat (2) @(posedge clk);
        if (errors == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_failed();
        end
    end

endmodule

// ==== rtl/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    ex_valid,
    input  pipeline_pkg::aluop_t    ex_aluop,
    input  pipeline_pkg::bus32_t    ex_pc,
    input  pipeline_pkg::bus32_t    ex_mem_addr,
    input  logic                    ex_reg_write_en,
    input  pipeline_pkg::reg_addr_t ex_reg_write_addr,
    input  pipeline_pkg::bus32_t    ex_reg_write_data,
    input  pipeline_pkg::csr_addr_t ex_csr_addr,
    input  logic                    ex_csr_read_en,
    input  logic                    ex_csr_write_en,
    input  pipeline_pkg::bus32_t    ex_csr_write_data,
    input  pipeline_pkg::bus32_t    ex_csr_mask,
    output logic                    pause_mem,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output pipeline_pkg::bus32_t    wb_adr,
    input  pipeline_pkg::bus32_t    wb_dat_i,
    input  logic                    wb_ack,
    output logic                    out_valid,
    output pipeline_pkg::bus32_t    out_pc,
    output logic                    out_write_en,
    output pipeline_pkg::reg_addr_t out_write_addr,
    output pipeline_pkg::bus32_t    out_write_data,
    output logic                    is_syscall_break,
    output logic                    is_ertn,
    output logic                    is_idle,
    output logic                    estat_access
);
    logic                    res_valid;
    pipeline_pkg::bus32_t    res_pc;
    logic                    res_write_en;
    pipeline_pkg::reg_addr_t res_write_addr;
    pipeline_pkg::bus32_t    res_write_data;
    logic                    res_csr_write_en;
    pipeline_pkg::csr_addr_t res_csr_addr;
    pipeline_pkg::bus32_t    res_csr_write_data;
    logic                    fwd_en;
    pipeline_pkg::csr_addr_t fwd_addr;
    pipeline_pkg::bus32_t    fwd_data;
    pipeline_pkg::bus64_t    timer;

    mem_load_if load_bus (.clk(clk), .arst_n(arst_n));
    mem_csr_if  csr_read_bus ();
    mem_csr_if  csr_commit_bus (); // writeback register to csr file.

    mem_stage u_mem_stage (
        .ex_valid(ex_valid), .ex_aluop(ex_aluop), .ex_pc(ex_pc),
        .ex_mem_addr(ex_mem_addr), .ex_reg_write_en(ex_reg_write_en),
        .ex_reg_write_addr(ex_reg_write_addr), .ex_reg_write_data(ex_reg_write_data),
        .ex_csr_addr(ex_csr_addr), .ex_csr_read_en(ex_csr_read_en),
        .ex_csr_write_en(ex_csr_write_en), .ex_csr_write_data(ex_csr_write_data),
        .ex_csr_mask(ex_csr_mask), .load(load_bus.master), .csr(csr_read_bus.reader),
        .fwd_en(fwd_en), .fwd_addr(fwd_addr), .fwd_data(fwd_data), .timer(timer),
        .pause_mem(pause_mem), .res_valid(res_valid), .res_pc(res_pc),
        .res_write_en(res_write_en), .res_write_addr(res_write_addr),
        .res_write_data(res_write_data), .res_csr_write_en(res_csr_write_en),
        .res_csr_addr(res_csr_addr), .res_csr_write_data(res_csr_write_data),
        .is_syscall_break(is_syscall_break), .is_ertn(is_ertn), .is_idle(is_idle),
        .estat_access(estat_access)
    );

    load_bus_port u_load_bus_port (
        .clk(clk), .arst_n(arst_n), .load(load_bus.slave),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

    csr_file u_csr_file (
        .clk(clk), .arst_n(arst_n), .csr_rd(csr_read_bus.owner),
        .csr_wr(csr_commit_bus.sink), .timer(timer)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk(clk), .arst_n(arst_n), .res_valid(res_valid), .res_pc(res_pc),
        .res_write_en(res_write_en), .res_write_addr(res_write_addr),
        .res_write_data(res_write_data), .res_csr_write_en(res_csr_write_en),
        .res_csr_addr(res_csr_addr), .res_csr_write_data(res_csr_write_data),
        .pause_mem(pause_mem), .out_valid(out_valid), .out_pc(out_pc),
        .out_write_en(out_write_en), .out_write_addr(out_write_addr),
        .out_write_data(out_write_data), .csr_wr(csr_commit_bus.writer),
        .fwd_en(fwd_en), .fwd_addr(fwd_addr), .fwd_data(fwd_data)
    );

endmodule

// ==== rtl/mem_wb_reg.sv ====
`timescale 1ns/1ps

module mem_wb_reg (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    res_valid,
    input  pipeline_pkg::bus32_t    res_pc,
    input  logic                    res_write_en,
    input  pipeline_pkg::reg_addr_t res_write_addr,
    input  pipeline_pkg::bus32_t    res_write_data,
    input  logic                    res_csr_write_en,
    input  pipeline_pkg::csr_addr_t res_csr_addr,
    input  pipeline_pkg::bus32_t    res_csr_write_data,
    input  logic                    pause_mem,
    output logic                    out_valid,
    output pipeline_pkg::bus32_t    out_pc,
    output logic                    out_write_en,
    output pipeline_pkg::reg_addr_t out_write_addr,
    output pipeline_pkg::bus32_t    out_write_data,
    mem_csr_if.writer               csr_wr,
    output logic                    fwd_en,
    output pipeline_pkg::csr_addr_t fwd_addr,
    output pipeline_pkg::bus32_t    fwd_data
);
    logic                    csr_we_q;
    pipeline_pkg::csr_addr_t csr_addr_q;
    pipeline_pkg::bus32_t    csr_data_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid    <= 1'b0;
            out_write_en <= 1'b0;
            csr_we_q     <= 1'b0;
        end else begin
            // a stalled stage sends a bubble down.
            out_valid    <= res_valid && !pause_mem;
            out_write_en <= res_write_en && !pause_mem;
            csr_we_q     <= res_csr_write_en && !pause_mem;
        end
    end

    always_ff @(posedge clk) begin
        out_pc         <= res_pc;
        out_write_addr <= res_write_addr;
        out_write_data <= res_write_data;
        csr_addr_q     <= res_csr_addr;
        csr_data_q     <= res_csr_write_data;
    end

    assign csr_wr.write_en   = csr_we_q;
    assign csr_wr.write_addr = csr_addr_q;
    assign csr_wr.write_data = csr_data_q;

    assign fwd_en   = csr_we_q;
    assign fwd_addr = csr_addr_q;
    assign fwd_data = csr_data_q;

    // enables come gated by valid from the stage, so none should appear in a bubble.
    a_we_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
        (out_write_en || csr_we_q) |-> out_valid);

endmodule

// ==== rtl/csr_file.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"

module csr_file (
    input  logic                 clk,
    input  logic                 arst_n,
    mem_csr_if.owner             csr_rd,
    mem_csr_if.sink              csr_wr,
    output pipeline_pkg::bus64_t timer
);
    pipeline_pkg::bus32_t crmd;
    pipeline_pkg::bus32_t estat;
    pipeline_pkg::bus32_t save0;
    pipeline_pkg::bus32_t save1;
    pipeline_pkg::bus32_t save2;
    pipeline_pkg::bus32_t save3;
    pipeline_pkg::bus32_t tid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            crmd  <= '0;
            estat <= '0;
            save0 <= '0;
            save1 <= '0;
            save2 <= '0;
            save3 <= '0;
            tid   <= '0;
        end else if (csr_wr.write_en) begin
            case (csr_wr.write_addr)
                `CSR_CRMD:  crmd  <= csr_wr.write_data;
                `CSR_ESTAT: estat <= csr_wr.write_data;
                `CSR_SAVE0: save0 <= csr_wr.write_data;
                `CSR_SAVE1: save1 <= csr_wr.write_data;
                `CSR_SAVE2: save2 <= csr_wr.write_data;
                `CSR_SAVE3: save3 <= csr_wr.write_data;
                `CSR_TID:   tid   <= csr_wr.write_data;
                default:    ;
            endcase
        end
    end

    // stable counter, never written by software.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            timer <= '0;
        end else begin
            timer <= timer + 64'd1;
        end
    end

    always_comb begin
        if (!csr_rd.read_en) begin
            csr_rd.read_data = '0;
        end else begin
            case (csr_rd.read_addr)
                `CSR_CRMD:  csr_rd.read_data = crmd;
                `CSR_ESTAT: csr_rd.read_data = estat;
                `CSR_SAVE0: csr_rd.read_data = save0;
                `CSR_SAVE1: csr_rd.read_data = save1;
                `CSR_SAVE2: csr_rd.read_data = save2;
                `CSR_SAVE3: csr_rd.read_data = save3;
                `CSR_TID:   csr_rd.read_data = tid;
                default:    csr_rd.read_data = '0;
            endcase
        end
    end

endmodule

// ==== rtl/load_bus_port.sv ====
`timescale 1ns/1ps

module load_bus_port (
    input  logic                 clk,
    input  logic                 arst_n,
    mem_load_if.slave            load,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output pipeline_pkg::bus32_t wb_adr,
    input  pipeline_pkg::bus32_t wb_dat_i,
    input  logic                 wb_ack
);
    pipeline_pkg::bus_state_t state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= pipeline_pkg::BUS_IDLE;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
        end else begin
            case (state)
                pipeline_pkg::BUS_IDLE: begin
                    if (load.req) begin
                        state  <= pipeline_pkg::BUS_WAIT;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                    end
                end
                default: begin
                    if (wb_ack) begin // a classic cycle carries one beat and then releases.
                        state  <= pipeline_pkg::BUS_IDLE;
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == pipeline_pkg::BUS_IDLE && load.req) begin
            wb_adr <= {load.addr[31:2], 2'b00}; // lane selection happens in the stage.
        end
    end

    assign load.data_ok = (state == pipeline_pkg::BUS_WAIT) && wb_ack;
    assign load.rdata   = wb_dat_i;

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!arst_n) wb_stb |-> wb_cyc);

endmodule

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_stage (
    input  logic                    ex_valid,
    input  pipeline_pkg::aluop_t    ex_aluop,
    input  pipeline_pkg::bus32_t    ex_pc,
    input  pipeline_pkg::bus32_t    ex_mem_addr,
    input  logic                    ex_reg_write_en,
    input  pipeline_pkg::reg_addr_t ex_reg_write_addr,
    input  pipeline_pkg::bus32_t    ex_reg_write_data,
    input  pipeline_pkg::csr_addr_t ex_csr_addr,
    input  logic                    ex_csr_read_en,
    input  logic                    ex_csr_write_en,
    input  pipeline_pkg::bus32_t    ex_csr_write_data,
    input  pipeline_pkg::bus32_t    ex_csr_mask,
    mem_load_if.master              load,
    mem_csr_if.reader               csr,
    input  logic                    fwd_en,
    input  pipeline_pkg::csr_addr_t fwd_addr,
    input  pipeline_pkg::bus32_t    fwd_data,
    input  pipeline_pkg::bus64_t    timer,
    output logic                    pause_mem,
    output logic                    res_valid,
    output pipeline_pkg::bus32_t    res_pc,
    output logic                    res_write_en,
    output pipeline_pkg::reg_addr_t res_write_addr,
    output pipeline_pkg::bus32_t    res_write_data,
    output logic                    res_csr_write_en,
    output pipeline_pkg::csr_addr_t res_csr_addr,
    output pipeline_pkg::bus32_t    res_csr_write_data,
    output logic                    is_syscall_break,
    output logic                    is_ertn,
    output logic                    is_idle,
    output logic                    estat_access
);
    logic                 is_load;
    logic                 is_csr_op;
    logic                 half_ok;
    logic [7:0]           byte_lane;
    logic [15:0]          half_lane;
    pipeline_pkg::bus32_t csr_old;

    assign is_load = (ex_aluop == `ALU_LDB) || (ex_aluop == `ALU_LDBU) ||
                     (ex_aluop == `ALU_LDH) || (ex_aluop == `ALU_LDHU) ||
                     (ex_aluop == `ALU_LDW) || (ex_aluop == `ALU_LLW);
    assign is_csr_op = (ex_aluop == `ALU_CSRRD) || (ex_aluop == `ALU_CSRWR) ||
                       (ex_aluop == `ALU_CSRXCHG);

    assign load.req  = ex_valid && is_load;
    assign load.addr = ex_mem_addr;
    assign pause_mem = load.req && !load.data_ok; // held until the bus returns data.

    // rdcntid is a plain read of the tid register.
    assign csr.read_en   = ex_valid && (ex_csr_read_en || (ex_aluop == `ALU_RDCNTID));
    assign csr.read_addr = (ex_aluop == `ALU_RDCNTID) ? `CSR_TID : ex_csr_addr;

    // a write still sitting in the writeback register is newer than the file.
    assign csr_old = (fwd_en && (fwd_addr == csr.read_addr)) ? fwd_data : csr.read_data;

    always_comb begin
        case (ex_mem_addr[1:0])
            2'b00:   byte_lane = load.rdata[7:0];
            2'b01:   byte_lane = load.rdata[15:8];
            2'b10:   byte_lane = load.rdata[23:16];
            default: byte_lane = load.rdata[31:24];
        endcase
    end

    assign half_lane = ex_mem_addr[1] ? load.rdata[31:16] : load.rdata[15:0];
    assign half_ok   = !ex_mem_addr[0];

    always_comb begin
        case (ex_aluop)
            `ALU_LDB:      res_write_data = {{24{byte_lane[7]}}, byte_lane};
            `ALU_LDBU:     res_write_data = {24'b0, byte_lane};
            `ALU_LDH:      res_write_data = half_ok ? {{16{half_lane[15]}}, half_lane} : '0;
            `ALU_LDHU:     res_write_data = half_ok ? {16'b0, half_lane} : '0;
            `ALU_LDW,
            `ALU_LLW:      res_write_data = load.rdata;
            `ALU_CSRRD,
            `ALU_CSRWR,
            `ALU_CSRXCHG,
            `ALU_RDCNTID:  res_write_data = csr_old;
            `ALU_RDCNTVLW: res_write_data = timer[31:0];
            `ALU_RDCNTVHW: res_write_data = timer[63:32];
            default:       res_write_data = ex_reg_write_data;
        endcase
    end

    assign res_valid      = ex_valid;
    assign res_pc         = ex_pc;
    assign res_write_en   = ex_valid && ex_reg_write_en;
    assign res_write_addr = ex_reg_write_addr;

    assign res_csr_write_en   = ex_valid && ex_csr_write_en;
    assign res_csr_addr       = ex_csr_addr;
    // csrxchg only replaces the bits selected by the mask.
    assign res_csr_write_data = (ex_aluop == `ALU_CSRXCHG) ?
                                ((csr_old & ~ex_csr_mask) | (ex_csr_write_data & ex_csr_mask)) :
                                ex_csr_write_data;

    assign is_syscall_break = ex_valid && ((ex_aluop == `ALU_SYSCALL) ||
                                           (ex_aluop == `ALU_BREAK));
    assign is_ertn      = ex_valid && (ex_aluop == `ALU_ERTN);
    assign is_idle      = ex_valid && (ex_aluop == `ALU_IDLE);
    assign estat_access = ex_valid && is_csr_op && (ex_csr_addr == `CSR_ESTAT);

    // the execute side must keep a waiting load in place until its data comes back.
    a_load_held: assert property (@(posedge load.clk) disable iff (!load.arst_n)
        load.req && !load.data_ok |=> load.req && $stable(load.addr));

endmodule

// ==== rtl/stage_ifs.sv ====
`timescale 1ns/1ps

interface mem_load_if (
    input logic clk,
    input logic arst_n
);
    logic                 req;
    pipeline_pkg::bus32_t addr;
    pipeline_pkg::bus32_t rdata;
    logic                 data_ok; // one cycle pulse, rdata is valid with it.

    // the stage side also sees the clock so that it can check the handshake.
    modport master (input clk, arst_n, rdata, data_ok, output req, addr);
    modport slave (input req, addr, output rdata, data_ok);
endinterface

interface mem_csr_if;
    logic                    read_en;
    pipeline_pkg::csr_addr_t read_addr;
    pipeline_pkg::bus32_t    read_data;
    logic                    write_en;
    pipeline_pkg::csr_addr_t write_addr;
    pipeline_pkg::bus32_t    write_data;

    modport reader (output read_en, read_addr, input read_data);
    modport owner (input read_en, read_addr, output read_data);
    modport writer (output write_en, write_addr, write_data);
    // the csr file takes the committed write through this side.
    modport sink (input write_en, write_addr, write_data);
endinterface

// ==== rtl/pipeline_pkg.sv ====
package pipeline_pkg;

    // one data word on the pipeline and the bus.
    typedef logic [31:0] bus32_t;

    // the stable timer is twice as wide as a data word.
    typedef logic [63:0] bus64_t;

    typedef logic [4:0] reg_addr_t; // general register number.

    typedef logic [13:0] csr_addr_t; // csr number as encoded in the instruction.

    typedef logic [7:0] aluop_t; // operation code decoded upstream.

    // the load port either waits for a request or waits for the ack.
    typedef enum logic {
        BUS_IDLE,
        BUS_WAIT
    } bus_state_t;

endpackage

// ==== rtl/mem_params.svh ====
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

`define ALU_NOP       8'h00
`define ALU_LDB       8'h10
`define ALU_LDBU      8'h11
`define ALU_LDH       8'h12
`define ALU_LDHU      8'h13
`define ALU_LDW       8'h14
`define ALU_LLW       8'h15
`define ALU_CSRRD     8'h20
`define ALU_CSRWR     8'h21
`define ALU_CSRXCHG   8'h22
`define ALU_RDCNTID   8'h30
`define ALU_RDCNTVLW  8'h31
`define ALU_RDCNTVHW  8'h32
`define ALU_SYSCALL   8'h40
`define ALU_BREAK     8'h41
`define ALU_ERTN      8'h42
`define ALU_IDLE      8'h43

// 14-bit csr numbers.
`define CSR_CRMD      14'h0000
`define CSR_ESTAT     14'h0005
`define CSR_SAVE0     14'h0030
`define CSR_SAVE1     14'h0031
`define CSR_SAVE2     14'h0032
`define CSR_SAVE3     14'h0033
`define CSR_TID       14'h0040

`endif
